/* cpu_pkg.sv */
package cpu_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 4;
  localparam int reg_count  = 2 ** reg_addr_w;

  // both memories are word addressed and ignore the two low address bits.
  localparam int imem_words = 64;
  localparam int imem_aw    = $clog2(imem_words);
  localparam int dmem_words = 64;
  localparam int dmem_aw    = $clog2(dmem_words);

  localparam logic [xlen-1:0] reset_pc = '0;

  // instruction class from the top of bits 27:24.
  localparam logic [1:0] cls_dp     = 2'b00;
  localparam logic [1:0] cls_mem    = 2'b01;
  localparam logic [2:0] cls_branch = 3'b101;
  localparam logic [3:0] cls_swi    = 4'hf;

  // condition field in bits 31:28.
  localparam logic [3:0] cond_eq = 4'h0;
  localparam logic [3:0] cond_ne = 4'h1;
  localparam logic [3:0] cond_ge = 4'ha;
  localparam logic [3:0] cond_lt = 4'hb;
  localparam logic [3:0] cond_al = 4'he;

  // data processing opcode in bits 24:21.
  localparam logic [3:0] op_and = 4'h0;
  localparam logic [3:0] op_sub = 4'h2;
  localparam logic [3:0] op_add = 4'h4;
  localparam logic [3:0] op_cmp = 4'ha;
  localparam logic [3:0] op_orr = 4'hc;
  localparam logic [3:0] op_mov = 4'hd;

  // bit positions in the nzcv word.
  localparam int flag_n = 3;
  localparam int flag_z = 2;
  localparam int flag_c = 1;
  localparam int flag_v = 0;

endpackage

/* fetch.sv */
module fetch
  import cpu_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            stall_i,
  input  logic            flush_i,
  input  logic            branch_i,
  input  logic [xlen-1:0] branch_address_i,
  output logic            valid_o,
  output logic [xlen-1:0] inst_o,
  output logic [xlen-1:0] pc_o,
  output logic            halted_o
);

  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] rom [imem_words];
  logic            swi_seen;

  initial begin
    $readmemh("program.hex", rom);
  end

  // an swi sitting in the shadow of a taken branch must not halt.
  assign swi_seen = valid_o && (inst_o[27:24] == cls_swi) && !branch_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q <= reset_pc;
    end else if (branch_i) begin
      pc_q <= branch_address_i;
    end else if (!stall_i && !halted_o && !swi_seen) begin
      pc_q <= pc_q + xlen'(4);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o  <= 1'b0;
      halted_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else if (swi_seen || halted_o) begin
      valid_o  <= 1'b0;
      halted_o <= 1'b1;
    end else if (!stall_i) begin
      valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      inst_o <= rom[pc_q[2 +: imem_aw]];
      pc_o   <= pc_q;
    end
  end

endmodule

/* decode_reg_r.sv */
module decode_reg_r
  import cpu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  flush_i,
  input  logic                  valid_i,
  input  logic [xlen-1:0]       inst_i,
  input  logic [xlen-1:0]       pc_i,
  input  logic                  wb_en_i,
  input  logic [reg_addr_w-1:0] wb_addr_i,
  input  logic [xlen-1:0]       wb_data_i,
  input  logic                  ex_busy_i,
  input  logic [reg_addr_w-1:0] ex_busy_addr_i,
  input  logic                  mem_busy_i,
  input  logic [reg_addr_w-1:0] mem_busy_addr_i,
  output logic                  valid_o,
  output logic [xlen-1:0]       inst_o,
  output logic [xlen-1:0]       pc_o,
  output logic [xlen-1:0]       r1_o,
  output logic [xlen-1:0]       r2_o,
  output logic [reg_addr_w-1:0] rd_addr_o,
  output logic                  stall_o
);

  logic [xlen-1:0]       regs [reg_count];
  logic [reg_addr_w-1:0] rn_addr;
  logic [reg_addr_w-1:0] rm_addr;
  logic [reg_addr_w-1:0] rd_addr;
  logic [reg_addr_w-1:0] r2_addr;
  logic [xlen-1:0]       rn_data;
  logic [xlen-1:0]       r2_data;
  logic                  is_dp;
  logic                  is_str;
  logic                  use_rn;
  logic                  use_r2;
  logic                  rn_busy;
  logic                  r2_busy;

  assign rn_addr = inst_i[19:16];
  assign rm_addr = inst_i[3:0];
  assign rd_addr = inst_i[15:12];

  assign is_dp  = inst_i[27:26] == cls_dp;
  assign is_str = (inst_i[27:26] == cls_mem) && !inst_i[20];

  // mov ignores rn, and a store reads its data from the rd field.
  assign use_rn  = (is_dp && inst_i[24:21] != op_mov) || (inst_i[27:26] == cls_mem);
  assign use_r2  = (is_dp && !inst_i[25]) || is_str;
  assign r2_addr = is_str ? rd_addr : rm_addr;

  always_ff @(posedge clk_i) begin
    if (wb_en_i) begin
      regs[wb_addr_i] <= wb_data_i;
    end
  end

  // same-cycle write-back goes straight to the read ports.
  assign rn_data = (wb_en_i && wb_addr_i == rn_addr) ? wb_data_i : regs[rn_addr];
  assign r2_data = (wb_en_i && wb_addr_i == r2_addr) ? wb_data_i : regs[r2_addr];

  assign rn_busy = (ex_busy_i && ex_busy_addr_i == rn_addr) ||
                   (mem_busy_i && mem_busy_addr_i == rn_addr);
  assign r2_busy = (ex_busy_i && ex_busy_addr_i == r2_addr) ||
                   (mem_busy_i && mem_busy_addr_i == r2_addr);

  assign stall_o = valid_i && ((use_rn && rn_busy) || (use_r2 && r2_busy));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else begin
      // a stalled slot goes forward as a bubble.
      valid_o <= valid_i && !stall_o;
    end
  end

  always_ff @(posedge clk_i) begin
    inst_o    <= inst_i;
    pc_o      <= pc_i;
    r1_o      <= rn_data;
    r2_o      <= r2_data;
    rd_addr_o <= rd_addr;
  end

endmodule

/* execute.sv */
module execute
  import cpu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  input  logic [xlen-1:0]       inst_i,
  input  logic [xlen-1:0]       pc_i,
  input  logic [xlen-1:0]       r1_i,
  input  logic [xlen-1:0]       r2_i,
  input  logic [reg_addr_w-1:0] rd_addr_i,
  output logic                  valid_o,
  output logic [xlen-1:0]       alu_data_o,
  output logic [xlen-1:0]       store_data_o,
  output logic [reg_addr_w-1:0] rd_addr_o,
  output logic                  do_write_o,
  output logic                  load_o,
  output logic                  store_o,
  output logic                  branch_o,
  output logic [xlen-1:0]       branch_address_o,
  output logic                  ex_busy_o,
  output logic [reg_addr_w-1:0] ex_busy_addr_o,
  output logic [3:0]            flags_o
);

  logic [3:0]      flags_q;
  logic [3:0]      new_flags;
  logic [3:0]      opcode;
  logic            is_dp;
  logic            is_mem;
  logic            is_b;
  logic            is_load;
  logic            set_flags;
  logic            will_write;
  logic            cond_ok;
  logic            fire;
  logic [xlen-1:0] op2;
  logic [xlen:0]   add_sum;
  logic [xlen:0]   sub_sum;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] mem_addr;

  assign opcode     = inst_i[24:21];
  assign is_dp      = inst_i[27:26] == cls_dp;
  assign is_mem     = inst_i[27:26] == cls_mem;
  assign is_b       = inst_i[27:25] == cls_branch;
  assign is_load    = is_mem && inst_i[20];
  assign set_flags  = is_dp && (inst_i[20] || opcode == op_cmp);
  assign will_write = (is_dp && opcode != op_cmp) || is_load;

  always_comb begin
    case (inst_i[31:28])
      cond_eq: cond_ok = flags_q[flag_z];
      cond_ne: cond_ok = !flags_q[flag_z];
      cond_lt: cond_ok = flags_q[flag_n] != flags_q[flag_v];
      cond_ge: cond_ok = flags_q[flag_n] == flags_q[flag_v];
      cond_al: cond_ok = 1'b1;
      default: cond_ok = 1'b0;
    endcase
  end

  // a failed condition leaves only a bubble behind.
  assign fire = valid_i && cond_ok;

  assign op2      = inst_i[25] ? {{(xlen-8){1'b0}}, inst_i[7:0]} : r2_i;
  assign add_sum  = {1'b0, r1_i} + {1'b0, op2};
  assign sub_sum  = {1'b0, r1_i} + {1'b0, ~op2} + {{xlen{1'b0}}, 1'b1};
  assign mem_addr = r1_i + {{(xlen-12){1'b0}}, inst_i[11:0]};

  always_comb begin
    alu_res   = r1_i;
    new_flags = flags_q;
    case (opcode)
      op_and: alu_res = r1_i & op2;
      op_orr: alu_res = r1_i | op2;
      op_mov: alu_res = op2;
      op_add: begin
        alu_res           = add_sum[xlen-1:0];
        new_flags[flag_c] = add_sum[xlen];
        new_flags[flag_v] = (r1_i[xlen-1] == op2[xlen-1]) && (add_sum[xlen-1] != r1_i[xlen-1]);
      end
      op_sub, op_cmp: begin
        alu_res           = sub_sum[xlen-1:0];
        new_flags[flag_c] = sub_sum[xlen];
        new_flags[flag_v] = (r1_i[xlen-1] != op2[xlen-1]) && (sub_sum[xlen-1] != r1_i[xlen-1]);
      end
      default: alu_res = r1_i;
    endcase
    new_flags[flag_n] = alu_res[xlen-1];
    new_flags[flag_z] = alu_res == '0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flags_q <= '0;
    end else if (fire && set_flags) begin
      flags_q <= new_flags;
    end
  end

  assign flags_o = flags_q;

  // target is pc + 8 plus the sign-extended word offset.
  assign branch_o         = fire && is_b;
  assign branch_address_o = pc_i + xlen'(8) + {{6{inst_i[23]}}, inst_i[23:0], 2'b00};

  assign ex_busy_o      = fire && will_write;
  assign ex_busy_addr_o = rd_addr_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o    <= 1'b0;
      do_write_o <= 1'b0;
      load_o     <= 1'b0;
      store_o    <= 1'b0;
    end else begin
      valid_o    <= fire && (is_dp || is_mem);
      do_write_o <= will_write;
      load_o     <= is_load;
      store_o    <= is_mem && !inst_i[20];
    end
  end

  always_ff @(posedge clk_i) begin
    alu_data_o   <= is_mem ? mem_addr : alu_res;
    store_data_o <= r2_i;
    rd_addr_o    <= rd_addr_i;
  end

endmodule

/* mem.sv */
module mem
  import cpu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  input  logic [xlen-1:0]       alu_data_i,
  input  logic [xlen-1:0]       store_data_i,
  input  logic [reg_addr_w-1:0] rd_addr_i,
  input  logic                  do_write_i,
  input  logic                  load_i,
  input  logic                  store_i,
  output logic                  wb_en_o,
  output logic [reg_addr_w-1:0] wb_addr_o,
  output logic [xlen-1:0]       wb_data_o,
  output logic                  mem_busy_o,
  output logic [reg_addr_w-1:0] mem_busy_addr_o
);

  logic [xlen-1:0]    dmem [dmem_words];
  logic [dmem_aw-1:0] word_addr;
  logic [xlen-1:0]    load_data;

  // addresses wrap around the data memory depth.
  assign word_addr = alu_data_i[2 +: dmem_aw];
  assign load_data = dmem[word_addr];

  always_ff @(posedge clk_i) begin
    if (valid_i && store_i) begin
      dmem[word_addr] <= store_data_i;
    end
  end

  assign mem_busy_o      = valid_i && do_write_i;
  assign mem_busy_addr_o = rd_addr_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_en_o <= 1'b0;
    end else begin
      wb_en_o <= valid_i && do_write_i;
    end
  end

  // the write-back register holds load data or the alu result.
  always_ff @(posedge clk_i) begin
    wb_addr_o <= rd_addr_i;
    wb_data_o <= load_i ? load_data : alu_data_i;
  end

endmodule

/* cpu.sv */
module cpu
  import cpu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  output logic                  retire_en_o,
  output logic [reg_addr_w-1:0] retire_addr_o,
  output logic [xlen-1:0]       retire_data_o,
  output logic [xlen-1:0]       pc_o,
  output logic [3:0]            flags_o,
  output logic                  led_o
);

  logic                  branch;
  logic [xlen-1:0]       branch_address;
  logic                  valid_fetch_to_decode;
  logic [xlen-1:0]       inst_fetch_to_decode;
  logic [xlen-1:0]       pc_fetch_to_decode;
  logic                  stall_decode_to_fetch;
  logic                  valid_rm_to_exec;
  logic [xlen-1:0]       inst_rm_to_exec;
  logic [xlen-1:0]       pc_rm_to_exec;
  logic [xlen-1:0]       r1_rm_to_exec;
  logic [xlen-1:0]       r2_rm_to_exec;
  logic [reg_addr_w-1:0] rd_addr_rm_to_exec;
  logic                  valid_exec_to_mem;
  logic [xlen-1:0]       alu_data_exec_to_mem;
  logic [xlen-1:0]       store_data_exec_to_mem;
  logic [reg_addr_w-1:0] rd_addr_exec_to_mem;
  logic                  do_write_exec_to_mem;
  logic                  load_exec_to_mem;
  logic                  store_exec_to_mem;
  logic                  ex_busy;
  logic [reg_addr_w-1:0] ex_busy_addr;
  logic                  mem_busy;
  logic [reg_addr_w-1:0] mem_busy_addr;
  logic                  wb_en;
  logic [reg_addr_w-1:0] wb_addr;
  logic [xlen-1:0]       wb_data;
  logic                  halted;

  fetch fetch_module (
      .clk_i            ( clk_i )
    , .reset_i          ( reset_i )
    , .stall_i          ( stall_decode_to_fetch )
    , .flush_i          ( branch )
    , .branch_i         ( branch )
    , .branch_address_i ( branch_address )
    , .valid_o          ( valid_fetch_to_decode )
    , .inst_o           ( inst_fetch_to_decode )
    , .pc_o             ( pc_fetch_to_decode )
    , .halted_o         ( halted )
  );

  decode_reg_r decode_module (
      .clk_i           ( clk_i )
    , .reset_i         ( reset_i )
    , .flush_i         ( branch )
    , .valid_i         ( valid_fetch_to_decode )
    , .inst_i          ( inst_fetch_to_decode )
    , .pc_i            ( pc_fetch_to_decode )
    , .wb_en_i         ( wb_en )
    , .wb_addr_i       ( wb_addr )
    , .wb_data_i       ( wb_data )
    , .ex_busy_i       ( ex_busy )
    , .ex_busy_addr_i  ( ex_busy_addr )
    , .mem_busy_i      ( mem_busy )
    , .mem_busy_addr_i ( mem_busy_addr )
    , .valid_o         ( valid_rm_to_exec )
    , .inst_o          ( inst_rm_to_exec )
    , .pc_o            ( pc_rm_to_exec )
    , .r1_o            ( r1_rm_to_exec )
    , .r2_o            ( r2_rm_to_exec )
    , .rd_addr_o       ( rd_addr_rm_to_exec )
    , .stall_o         ( stall_decode_to_fetch )
  );

  execute execute_module (
      .clk_i            ( clk_i )
    , .reset_i          ( reset_i )
    , .valid_i          ( valid_rm_to_exec )
    , .inst_i           ( inst_rm_to_exec )
    , .pc_i             ( pc_rm_to_exec )
    , .r1_i             ( r1_rm_to_exec )
    , .r2_i             ( r2_rm_to_exec )
    , .rd_addr_i        ( rd_addr_rm_to_exec )
    , .valid_o          ( valid_exec_to_mem )
    , .alu_data_o       ( alu_data_exec_to_mem )
    , .store_data_o     ( store_data_exec_to_mem )
    , .rd_addr_o        ( rd_addr_exec_to_mem )
    , .do_write_o       ( do_write_exec_to_mem )
    , .load_o           ( load_exec_to_mem )
    , .store_o          ( store_exec_to_mem )
    , .branch_o         ( branch )
    , .branch_address_o ( branch_address )
    , .ex_busy_o        ( ex_busy )
    , .ex_busy_addr_o   ( ex_busy_addr )
    , .flags_o          ( flags_o )
  );

  mem memory_module (
      .clk_i           ( clk_i )
    , .reset_i         ( reset_i )
    , .valid_i         ( valid_exec_to_mem )
    , .alu_data_i      ( alu_data_exec_to_mem )
    , .store_data_i    ( store_data_exec_to_mem )
    , .rd_addr_i       ( rd_addr_exec_to_mem )
    , .do_write_i      ( do_write_exec_to_mem )
    , .load_i          ( load_exec_to_mem )
    , .store_i         ( store_exec_to_mem )
    , .wb_en_o         ( wb_en )
    , .wb_addr_o       ( wb_addr )
    , .wb_data_o       ( wb_data )
    , .mem_busy_o      ( mem_busy )
    , .mem_busy_addr_o ( mem_busy_addr )
  );

  // each write-back pulse is one retired instruction.
  assign retire_en_o   = wb_en;
  assign retire_addr_o = wb_addr;
  assign retire_data_o = wb_data;
  assign pc_o          = pc_fetch_to_decode;
  assign led_o         = halted;

endmodule

/* cpu_props.sv */
module cpu_props
  import cpu_pkg::*;
(
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  retire_en_i,
  input logic [reg_addr_w-1:0] retire_addr_i,
  input logic [xlen-1:0]       pc_i,
  input logic                  led_i,
  input logic                  branch_i,
  input logic [xlen-1:0]       branch_address_i
);

  int unsigned reset_fails = 0;
  int unsigned pc_fails    = 0;
  int unsigned addr_fails  = 0;
  int unsigned led_fails   = 0;
  int unsigned fail_count;

  assign fail_count = reset_fails + pc_fails + addr_fails + led_fails;

  quiet_after_reset: assert property (
    @(posedge clk_i) reset_i |=> !retire_en_i && !led_i
  ) else begin
    reset_fails++;
    $error("retire or led active in the cycle after reset");
  end

  // a branch target shows up on pc two cycles after the branch.
  pc_steps: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> pc_i == $past(pc_i) || pc_i == $past(pc_i) + xlen'(4) ||
                        ($past(branch_i, 2) && pc_i == $past(branch_address_i, 2))
  ) else begin
    pc_fails++;
    $error("pc moved to %h, neither a step of 4 nor a branch target", pc_i);
  end

  no_pc_write: assert property (
    @(posedge clk_i) disable iff (reset_i) retire_en_i |-> retire_addr_i != reg_addr_w'(15)
  ) else begin
    addr_fails++;
    $error("an instruction retired into r15");
  end

  led_sticks: assert property (
    @(posedge clk_i) disable iff (reset_i) led_i |=> led_i
  ) else begin
    led_fails++;
    $error("led went dark after the halt");
  end

endmodule

bind cpu cpu_props u_props (
  .clk_i            ( clk_i ),
  .reset_i          ( reset_i ),
  .retire_en_i      ( retire_en_o ),
  .retire_addr_i    ( retire_addr_o ),
  .pc_i             ( pc_o ),
  .led_i            ( led_o ),
  .branch_i         ( branch ),
  .branch_address_i ( branch_address )
);

/* cpu_tb.sv */
module cpu_tb
  import cpu_pkg::*;
();

  localparam int half_period     = 20;
  localparam int reset_cycles    = 5;
  localparam int quiet_cycles    = 10;
  localparam int cycles_per_inst = 4;
  localparam int timeout_margin  = 200;
  localparam int max_model_steps = 1000;

  logic                  clk;
  logic                  reset;
  logic                  retire_en;
  logic [reg_addr_w-1:0] retire_addr;
  logic [xlen-1:0]       retire_data;
  logic [xlen-1:0]       pc;
  logic [3:0]            flags;
  logic                  led;

  logic [xlen-1:0]       prog [imem_words];
  logic [xlen-1:0]       model_regs [reg_count];
  logic [xlen-1:0]       model_mem [dmem_words];
  logic [3:0]            model_flags;
  logic [reg_addr_w-1:0] exp_addr_q [$];
  logic [xlen-1:0]       exp_data_q [$];
  int                    expected_total;
  bit                    model_ready;
  int                    mismatch_count;
  int                    other_count;

  cpu u_dut (
    .clk_i         ( clk ),
    .reset_i       ( reset ),
    .retire_en_o   ( retire_en ),
    .retire_addr_o ( retire_addr ),
    .retire_data_o ( retire_data ),
    .pc_o          ( pc ),
    .flags_o       ( flags ),
    .led_o         ( led )
  );

  always #half_period clk = ~clk;

  function automatic bit cond_holds(logic [3:0] cond, logic [3:0] f);
    case (cond)
      cond_eq: return f[flag_z];
      cond_ne: return !f[flag_z];
      cond_lt: return f[flag_n] ^ f[flag_v];
      cond_ge: return !(f[flag_n] ^ f[flag_v]);
      cond_al: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic model_write(logic [reg_addr_w-1:0] rd, logic [xlen-1:0] value);
    model_regs[rd] = value;
    exp_addr_q.push_back(rd);
    exp_data_q.push_back(value);
  endtask

  task automatic model_dp(logic [xlen-1:0] inst);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] res;
    logic [3:0]      op;
    logic [3:0]      f;
    longint          wide;
    op  = inst[24:21];
    a   = model_regs[inst[19:16]];
    b   = inst[25] ? {24'b0, inst[7:0]} : model_regs[inst[3:0]];
    f   = model_flags;
    res = a;
    case (op)
      op_and: res = a & b;
      op_orr: res = a | b;
      op_mov: res = b;
      op_add: begin
        res       = a + b;
        wide      = longint'(a) + longint'(b);
        f[flag_c] = wide[xlen];
        wide      = longint'($signed(a)) + longint'($signed(b));
        f[flag_v] = wide != longint'($signed(res));
      end
      op_sub, op_cmp: begin
        res       = a - b;
        f[flag_c] = a >= b;
        wide      = longint'($signed(a)) - longint'($signed(b));
        f[flag_v] = wide != longint'($signed(res));
      end
      default: res = a;
    endcase
    // logical ops keep c and v as they were.
    if (inst[20] || op == op_cmp) begin
      f[flag_n]   = res[xlen-1];
      f[flag_z]   = res == '0;
      model_flags = f;
    end
    if (op != op_cmp) begin
      model_write(inst[15:12], res);
    end
  endtask

  task automatic run_model();
    logic [xlen-1:0] mpc;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] inst;
    logic [xlen-1:0] addr;
    int              offset;
    int              steps;
    bit              halted;
    mpc         = reset_pc;
    halted      = 1'b0;
    steps       = 0;
    model_flags = '0;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    while (!halted && steps < max_model_steps) begin
      inst    = prog[mpc[2 +: imem_aw]];
      next_pc = mpc + 32'd4;
      steps++;
      if (cond_holds(inst[31:28], model_flags)) begin
        if (inst[27:24] == cls_swi) begin
          halted = 1'b1;
        end else if (inst[27:25] == cls_branch) begin
          offset  = int'($signed(inst[23:0]));
          next_pc = mpc + 32'd8 + 32'(offset * 4);
        end else if (inst[27:26] == cls_mem) begin
          addr = model_regs[inst[19:16]] + {20'b0, inst[11:0]};
          if (inst[20]) begin
            model_write(inst[15:12], model_mem[addr[2 +: dmem_aw]]);
          end else begin
            model_mem[addr[2 +: dmem_aw]] = model_regs[inst[15:12]];
          end
        end else begin
          model_dp(inst);
        end
      end
      mpc = next_pc;
    end
    assert (halted) else begin
      $display("ERROR: the reference model found no swi within %0d steps", max_model_steps);
      other_count++;
    end
  endtask

  task automatic report_mismatch(string name, logic [xlen-1:0] expected,
                                 logic [xlen-1:0] actual);
    $display("[FAIL] time %0t: %s expected %h, got %h", $time, name, expected, actual);
    mismatch_count++;
  endtask

  task automatic check_retire();
    logic [reg_addr_w-1:0] exp_addr;
    logic [xlen-1:0]       exp_data;
    assert (exp_addr_q.size() > 0) else begin
      $display("ERROR at time %0t: r%0d was written after the last expected write",
               $time, retire_addr);
      other_count++;
    end
    if (exp_addr_q.size() > 0) begin
      exp_addr = exp_addr_q.pop_front();
      exp_data = exp_data_q.pop_front();
      assert (retire_addr === exp_addr) else begin
        report_mismatch("retire_addr_o", xlen'(exp_addr), xlen'(retire_addr));
      end
      assert (retire_data === exp_data) else begin
        report_mismatch("retire_data_o", exp_data, retire_data);
      end
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d value mismatches, %0d other failures, %0d property failures",
             mismatch_count, other_count, u_dut.u_props.fail_count);
  endtask

  always @(negedge clk) begin
    if (!reset && retire_en === 1'b1) begin
      check_retire();
    end
  end

  initial begin
    wait (model_ready);
    repeat (expected_total * cycles_per_inst + timeout_margin) @(posedge clk);
    $display("ERROR: timeout, the program did not halt within %0d cycles",
             expected_total * cycles_per_inst + timeout_margin);
    other_count++;
    print_counts();
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int total;
    clk            = 1'b0;
    reset          = 1'b1;
    mismatch_count = 0;
    other_count    = 0;
    $readmemh("program.hex", prog);
    run_model();
    expected_total = exp_addr_q.size();
    model_ready    = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    // older instructions still drain after the led comes on.
    while (!(led === 1'b1 && exp_addr_q.size() == 0)) begin
      @(negedge clk);
    end
    repeat (quiet_cycles) @(negedge clk);
    assert (flags === model_flags) else begin
      report_mismatch("flags_o", xlen'(model_flags), xlen'(flags));
    end
    total = mismatch_count + other_count + int'(u_dut.u_props.fail_count);
    print_counts();
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* program.hex */
// one 32-bit instruction word per line, starting at address 0.
// alu and dependent ops, store and load, a loop, compares, branches, then swi.
e3a01005
e3a0200c
e0813002
e2434002
e2045006
e1856001
e3817030
e0068003
e0429001
e1a0a009
e5823008
e592b008
e28bc001
e3a00003
e2811002
e2500001
1afffffc
e351000b
03a02001
13a03002
e1590004
b3a04044
a3a05055
aa000001
ba000001
e3a06066
e3a07077
e3a08088
ef000000
e3a09099

/* cpu.f */
cpu_pkg.sv
fetch.sv
decode_reg_r.sv
execute.sv
mem.sv
cpu.sv
cpu_props.sv
cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
